// ==== ieu_config.svh ====
// width settings shared by the integer execution unit
// data and address are fixed at 32 bits by RV32I

`ifndef IEU_CONFIG_SVH
`define IEU_CONFIG_SVH

// one operand or result word
`define DATA_WIDTH 32

// instruction address
`define ADDR_WIDTH 32

// reorder-buffer tag, enough for a 64 entry ROB
`define TAG_WIDTH 6

`endif

// ==== ieu_pkg.sv ====
// width typedefs, opcode and ALU function enums, stage and CDB structs

`include "ieu_config.svh"

package ieu_pkg;

    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [`TAG_WIDTH-1:0]  tag_t;
    typedef logic [4:0]             shamt_t;

    // major opcodes as encoded in insn[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    // arithmetic functions first, then the six branch compares
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        BEQ, BNE, BLT, BGE, BLTU, BGEU
    } alu_func_t;

    typedef struct packed {
        alu_func_t alu_func;
        data_t     src_a;
        data_t     src_b;
        addr_t     iaddr;
        data_t     imm_b;    // jump or branch offset
        shamt_t    shamt;
        tag_t      tag;
        logic      jmp;
        logic      br;
        logic      valid;
    } id_bundle_t;

    typedef struct packed {
        data_t data;
        addr_t addr;
        tag_t  tag;
        logic  redirect;
        logic  valid;
    } cdb_t;

endpackage

// ==== ieu_id.sv ====
// decode stage of the integer execution unit
// builds the execute bundle from an issued RV32I instruction

`timescale 1ns/1ns

module ieu_id
    import ieu_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       i_valid,
    input  opcode_t    i_opcode,
    input  addr_t      i_iaddr,
    input  data_t      i_insn,
    input  data_t      i_src_a,
    input  data_t      i_src_b,
    input  tag_t       i_tag,
    output id_bundle_t o_id
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    data_t      imm_i;
    data_t      imm_u;
    data_t      imm_j;
    data_t      imm_br;
    alu_func_t  arith_func;
    alu_func_t  branch_func;

    assign funct3 = i_insn[14:12];
    assign funct7 = i_insn[31:25];

    // immediates in their RV32I bit orders, sign extended
    assign imm_i  = {{20{i_insn[31]}}, i_insn[31:20]};
    assign imm_u  = {i_insn[31:12], 12'b0};
    assign imm_j  = {{12{i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
    assign imm_br = {{20{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  arith_func = (i_opcode == OPC_OP && funct7[5]) ? SUB : ADD; // no SUBI
            3'b001:  arith_func = SLL;
            3'b010:  arith_func = SLT;
            3'b011:  arith_func = SLTU;
            3'b100:  arith_func = XOR;
            3'b101:  arith_func = funct7[5] ? SRA : SRL; // SRAI shares the bit with SRA
            3'b110:  arith_func = OR;
            default: arith_func = AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b001:  branch_func = BNE;
            3'b100:  branch_func = BLT;
            3'b101:  branch_func = BGE;
            3'b110:  branch_func = BLTU;
            3'b111:  branch_func = BGEU;
            default: branch_func = BEQ;
        endcase
    end

    always_comb begin
        o_id.alu_func = arith_func;
        o_id.src_a    = i_src_a;
        o_id.src_b    = i_src_b;
        o_id.iaddr    = i_iaddr;
        o_id.imm_b    = imm_br;
        o_id.shamt    = i_src_b[4:0];   // register shifts take the low bits of rs2
        o_id.tag      = i_tag;
        o_id.jmp      = 1'b0;
        o_id.br       = 1'b0;
        o_id.valid    = i_valid;
        case (i_opcode)
            OPC_OP_IMM: begin
                o_id.src_b = imm_i;
                o_id.shamt = i_insn[24:20];
            end
            OPC_LUI, OPC_AUIPC: begin
                o_id.alu_func = ADD;
                o_id.src_a    = (i_opcode == OPC_AUIPC) ? data_t'(i_iaddr) : '0;
                o_id.src_b    = imm_u;
            end
            OPC_JAL: begin
                // target is pc relative, so the adder in EX sees iaddr as its base
                o_id.alu_func = ADD;
                o_id.src_a    = data_t'(i_iaddr);
                o_id.imm_b    = imm_j;
                o_id.jmp      = 1'b1;
            end
            OPC_JALR: begin
                o_id.alu_func = ADD;
                o_id.imm_b    = imm_i;
                o_id.jmp      = 1'b1;
            end
            OPC_BRANCH: begin
                o_id.alu_func = branch_func;
                o_id.br       = 1'b1;
            end
            default: ;
        endcase
    end

    // the issue logic only forwards legal OP encodings
    a_op_funct_legal: assert property (@(posedge clk) disable iff (!n_rst)
        (i_valid && i_opcode == OPC_OP) |->
            (funct7 == 7'b0000000 ||
             (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))))
        else $error("illegal funct3/funct7 pair %b/%b on OP", funct3, funct7);

endmodule

// ==== ieu_ex.sv ====
// execute stage of the integer execution unit
// ALU, branch compare, link value and next address

`timescale 1ns/1ns

module ieu_ex
    import ieu_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  id_bundle_t i_id,
    output cdb_t       o_ex
);

    data_t alu_res;
    logic  taken;
    addr_t seq_addr;
    addr_t br_target;
    addr_t jmp_sum;
    addr_t jmp_target;

    always_comb begin
        case (i_id.alu_func)
            ADD:     alu_res = i_id.src_a + i_id.src_b;
            SUB:     alu_res = i_id.src_a - i_id.src_b;
            SLL:     alu_res = i_id.src_a << i_id.shamt;
            SLT:     alu_res = data_t'($signed(i_id.src_a) < $signed(i_id.src_b));
            SLTU:    alu_res = data_t'(i_id.src_a < i_id.src_b);
            XOR:     alu_res = i_id.src_a ^ i_id.src_b;
            SRL:     alu_res = i_id.src_a >> i_id.shamt;
            SRA:     alu_res = data_t'($signed(i_id.src_a) >>> i_id.shamt);
            OR:      alu_res = i_id.src_a | i_id.src_b;
            AND:     alu_res = i_id.src_a & i_id.src_b;
            default: alu_res = '0; // compare functions give no data
        endcase
    end

    always_comb begin
        case (i_id.alu_func)
            BEQ:     taken = (i_id.src_a == i_id.src_b);
            BNE:     taken = (i_id.src_a != i_id.src_b);
            BLT:     taken = ($signed(i_id.src_a) < $signed(i_id.src_b));
            BGE:     taken = ($signed(i_id.src_a) >= $signed(i_id.src_b));
            BLTU:    taken = (i_id.src_a < i_id.src_b);
            BGEU:    taken = (i_id.src_a >= i_id.src_b);
            default: taken = 1'b0;
        endcase
    end

    assign seq_addr   = i_id.iaddr + addr_t'(4);
    assign br_target  = i_id.iaddr + addr_t'(i_id.imm_b);
    assign jmp_sum    = addr_t'(i_id.src_a + i_id.imm_b);
    assign jmp_target = {jmp_sum[$bits(addr_t)-1:1], 1'b0}; // JALR drops bit 0

    always_comb begin
        o_ex.tag   = i_id.tag;
        o_ex.valid = i_id.valid;
        if (i_id.jmp) begin
            o_ex.data     = data_t'(seq_addr);  // link value
            o_ex.addr     = jmp_target;
            o_ex.redirect = 1'b1;
        end else if (i_id.br) begin
            o_ex.data     = '0;
            o_ex.addr     = taken ? br_target : seq_addr;
            o_ex.redirect = taken;
        end else begin
            o_ex.data     = alu_res;
            o_ex.addr     = seq_addr;
            o_ex.redirect = 1'b0;
        end
    end

    // fetch is only ever redirected by control flow decoded in ID, and never by both kinds
    a_redirect_ctrl: assert property (@(posedge clk) disable iff (!n_rst)
        (i_id.valid && o_ex.redirect) |-> (i_id.jmp ^ i_id.br))
        else $error("redirect without a single jump or branch, tag %0d", i_id.tag);

endmodule

// ==== ieu.sv ====
// integer execution unit top with the ID and EX stages
// pipeline registers, flush handling and the CDB drive

`timescale 1ns/1ns

module ieu
    import ieu_pkg::*;
(
    input  logic    clk,
    input  logic    n_rst,
    input  logic    i_flush,
    input  logic    i_fu_valid,
    input  opcode_t i_fu_opcode,
    input  addr_t   i_fu_iaddr,
    input  data_t   i_fu_insn,
    input  data_t   i_fu_src_a,
    input  data_t   i_fu_src_b,
    input  tag_t    i_fu_tag,
    output cdb_t    o_cdb
);

    id_bundle_t id_d;
    id_bundle_t id_q;
    id_bundle_t ex_in;
    cdb_t       ex_d;
    cdb_t       ex_q;
    logic       id_valid_q;
    logic       ex_valid_q;

    ieu_id u_id (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_valid  (i_fu_valid),
        .i_opcode (i_fu_opcode),
        .i_iaddr  (i_fu_iaddr),
        .i_insn   (i_fu_insn),
        .i_src_a  (i_fu_src_a),
        .i_src_b  (i_fu_src_b),
        .i_tag    (i_fu_tag),
        .o_id     (id_d)
    );

    // stage valids clear on reset and on flush, so both instructions in flight are dropped
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            id_valid_q <= 1'b0;
            ex_valid_q <= 1'b0;
        end else begin
            id_valid_q <= id_d.valid & ~i_flush;
            ex_valid_q <= ex_d.valid & ~i_flush;
        end
    end

    always_ff @(posedge clk) begin
        id_q <= id_d;
        ex_q <= ex_d;
    end

    always_comb begin
        ex_in       = id_q;
        ex_in.valid = id_valid_q;
    end

    ieu_ex u_ex (
        .clk   (clk),
        .n_rst (n_rst),
        .i_id  (ex_in),
        .o_ex  (ex_d)
    );

    always_comb begin
        o_cdb       = ex_q;
        o_cdb.valid = ex_valid_q;
    end

    // both instructions caught by a flush stay off the CDB
    a_flush_quiet: assert property (@(posedge clk) disable iff (!n_rst)
        (i_flush || $past(i_flush)) |=> !o_cdb.valid)
        else $error("CDB valid within two cycles after a flush");

endmodule

// ==== tb_ieu.sv ====
// testbench for the integer execution unit
// replays the golden vectors on falling edges and checks every CDB word

`timescale 1ns/1ns

module tb_ieu
    import ieu_pkg::*;
();

    localparam int NUM_VEC    = 39;
    localparam int WORDS      = 14;  // hex words per golden line
    localparam int RST_CYCLES = 10;
    localparam int MAX_CYCLES = NUM_VEC + RST_CYCLES + 20;

    logic    clk;
    logic    n_rst;
    logic    i_flush;
    logic    i_fu_valid;
    opcode_t i_fu_opcode;
    addr_t   i_fu_iaddr;
    data_t   i_fu_insn;
    data_t   i_fu_src_a;
    data_t   i_fu_src_b;
    tag_t    i_fu_tag;
    cdb_t    o_cdb;

    logic [31:0] golden [0:NUM_VEC*WORDS-1];
    cdb_t        exp_q[$];  // expected words still in flight
    int          errors       = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycles       = 0;

    ieu uut (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_flush     (i_flush),
        .i_fu_valid  (i_fu_valid),
        .i_fu_opcode (i_fu_opcode),
        .i_fu_iaddr  (i_fu_iaddr),
        .i_fu_insn   (i_fu_insn),
        .i_fu_src_a  (i_fu_src_a),
        .i_fu_src_b  (i_fu_src_b),
        .i_fu_tag    (i_fu_tag),
        .o_cdb       (o_cdb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the run was still going after %0d clock cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_bit(input string name, input logic want, input logic got);
        if (got !== want) begin
            $display("FAIL at %0t ns: %s expected %b, got %b", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic check_cdb(input cdb_t want, input cdb_t got);
        check_bit("o_cdb.valid", want.valid, got.valid);
        check_bit("o_cdb.redirect", want.redirect, got.redirect);
        if (got.tag !== want.tag) begin
            $display("FAIL at %0t ns: o_cdb.tag expected %h, got %h", $time, want.tag, got.tag);
            errors++;
        end
        if (got.addr !== want.addr) begin
            $display("FAIL at %0t ns: o_cdb.addr expected %h, got %h", $time, want.addr, got.addr);
            errors++;
        end
        if (got.data !== want.data) begin
            $display("FAIL at %0t ns: o_cdb.data expected %h, got %h", $time, want.data, got.data);
            errors++;
        end
    endtask

    function automatic int vector_test(input int idx);
        return int'(golden[idx*WORDS]);
    endfunction

    function automatic string test_name(input int num);
        case (num)
            1:       return "register and immediate arithmetic";
            2:       return "LUI and AUIPC";
            3:       return "JAL and JALR";
            4:       return "branch compares";
            5:       return "back-to-back issue";
            6:       return "flush with two in flight";
            default: return "unnamed";
        endcase
    endfunction

    task automatic report_test(input int num, input int first_err);
        if (errors == first_err) begin
            $display("test %0d (%s): pass", num, test_name(num));
            tests_passed++;
        end else begin
            $display("test %0d (%s): %0d errors", num, test_name(num), errors - first_err);
            tests_failed++;
        end
    endtask

    // applies one golden line to the DUT and queues its expected CDB word
    task automatic drive_vector(input int idx);
        int   b;
        cdb_t want;
        b = idx * WORDS;
        i_fu_valid    = golden[b+1][0];
        i_fu_opcode   = opcode_t'(golden[b+2][6:0]);
        i_fu_iaddr    = golden[b+3];
        i_fu_insn     = golden[b+4];
        i_fu_src_a    = golden[b+5];
        i_fu_src_b    = golden[b+6];
        i_fu_tag      = tag_t'(golden[b+7]);
        i_flush       = golden[b+8][0];
        want.valid    = golden[b+9][0];
        want.redirect = golden[b+10][0];
        want.tag      = tag_t'(golden[b+11]);
        want.addr     = golden[b+12];
        want.data     = golden[b+13];
        exp_q.push_back(want);
    endtask

    initial begin
        int   idx;
        int   first_err;
        cdb_t want;
        n_rst       = 1'b0;
        i_flush     = 1'b0;
        i_fu_valid  = 1'b0;
        i_fu_opcode = OPC_OP;
        i_fu_iaddr  = '0;
        i_fu_insn   = '0;
        i_fu_src_a  = '0;
        i_fu_src_b  = '0;
        i_fu_tag    = '0;
        first_err   = 0;
        $readmemh("ieu_golden.txt", golden);

        repeat (RST_CYCLES) begin
            @(negedge clk);
            check_bit("o_cdb.valid", 1'b0, o_cdb.valid); // no result while in reset
        end
        n_rst = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_bit("o_cdb.valid", 1'b0, o_cdb.valid); // pipeline comes out of reset empty
        end
        if (errors == 0) begin
            $display("reset: o_cdb.valid stayed low through reset and the cycles after it");
            tests_passed++;
        end else begin
            $display("reset: o_cdb.valid went high during or right after reset");
            tests_failed++;
        end

        // each word shows up on the CDB two falling edges after its vector is driven
        for (int v = 0; v < NUM_VEC + 2; v++) begin
            if (v >= 2) begin
                idx = v - 2;
                if (idx == 0 || vector_test(idx) != vector_test(idx - 1))
                    first_err = errors;
                want = exp_q.pop_front();
                if (want.valid)
                    check_cdb(want, o_cdb);
                else
                    check_bit("o_cdb.valid", 1'b0, o_cdb.valid);
                if (idx == NUM_VEC - 1 || vector_test(idx + 1) != vector_test(idx))
                    report_test(vector_test(idx), first_err);
            end
            if (v < NUM_VEC) begin
                drive_vector(v);
            end else begin
                i_fu_valid = 1'b0;
                i_flush    = 1'b0;
            end
            @(negedge clk);
        end

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== ieu_golden.txt ====
// test valid opcode iaddr insn src_a src_b tag flush, then the expected CDB word:
// valid redirect tag addr data (all hex, one vector per line)
1 1 33 00001000 002081B3 7FFFFFFF 00000001 01 0 1 0 01 00001004 80000000
1 1 33 00001004 402081B3 00000003 00000005 02 0 1 0 02 00001008 FFFFFFFE
1 1 33 00001008 002091B3 0000000F 00000024 03 0 1 0 03 0000100C 000000F0
1 1 33 0000100C 0020A1B3 FFFFFFFF 00000001 04 0 1 0 04 00001010 00000001
1 1 33 00001010 0020B1B3 FFFFFFFF 00000001 05 0 1 0 05 00001014 00000000
1 1 33 00001014 0020C1B3 FF00FF00 0FF00FF0 06 0 1 0 06 00001018 F0F0F0F0
1 1 33 00001018 0020D1B3 80000000 0000001F 07 0 1 0 07 0000101C 00000001
1 1 33 0000101C 4020D1B3 80000000 00000004 08 0 1 0 08 00001020 F8000000
1 1 33 00001020 0020E1B3 12340000 00005678 09 0 1 0 09 00001024 12345678
1 1 33 00001024 0020F1B3 F0F0F0F0 3C3C3C3C 0A 0 1 0 0A 00001028 30303030
1 1 13 00001028 FFF08193 00000010 DEADBEEF 0B 0 1 0 0B 0000102C 0000000F
1 1 13 0000102C 00809193 000000AB 00000003 0C 0 1 0 0C 00001030 0000AB00
1 1 13 00001030 4080D193 87654321 00000001 0D 0 1 0 0D 00001034 FF876543
1 1 13 00001034 0040D193 87654321 00000001 0E 0 1 0 0E 00001038 08765432
1 1 13 00001038 0050A193 FFFFFFF0 00000000 0F 0 1 0 0F 0000103C 00000001
2 1 37 00002000 123451B7 FFFFFFFF 00000000 11 0 1 0 11 00002004 12345000
2 1 17 00002004 00001197 55555555 00000000 12 0 1 0 12 00002008 00003004
3 1 6F 00003000 100000EF 11111111 00000000 14 0 1 1 14 00003100 00003004
3 1 6F 00003010 FF9FF0EF 11111111 00000000 15 0 1 1 15 00003008 00003014
3 1 67 00003020 005100E7 00004000 00000000 16 0 1 1 16 00004004 00003024
3 1 67 00003030 FFC100E7 00005001 00000000 17 0 1 1 17 00004FFC 00003034
4 1 63 00004000 00208863 00000005 00000005 18 0 1 1 18 00004010 00000000
4 1 63 00004004 00208863 00000005 00000006 19 0 1 0 19 00004008 00000000
4 1 63 00004020 FE2098E3 00000001 00000002 1A 0 1 1 1A 00004010 00000000
4 1 63 00004024 00209863 00000007 00000007 1B 0 1 0 1B 00004028 00000000
4 1 63 00004030 0020C863 FFFFFFFF 00000001 1C 0 1 1 1C 00004040 00000000
4 1 63 00004034 0020C863 00000001 FFFFFFFF 1D 0 1 0 1D 00004038 00000000
4 1 63 00004040 0020D863 00000003 00000003 1E 0 1 1 1E 00004050 00000000
4 1 63 00004044 0020D863 80000000 00000000 1F 0 1 0 1F 00004048 00000000
4 1 63 00004050 0020E863 00000001 FFFFFFFF 20 0 1 1 20 00004060 00000000
4 1 63 00004054 0020E863 FFFFFFFF 00000001 21 0 1 0 21 00004058 00000000
4 1 63 00004060 0020F863 FFFFFFFF 00000001 22 0 1 1 22 00004070 00000000
4 1 63 00004064 0020F863 00000000 00000001 23 0 1 0 23 00004068 00000000
5 1 33 00005000 002081B3 00000001 00000002 24 0 1 0 24 00005004 00000003
5 0 33 00005004 002081B3 00000000 00000000 00 0 0 0 00 00000000 00000000
5 1 33 00005008 0020C1B3 0000000A 00000005 25 0 1 0 25 0000500C 0000000F
6 1 33 00006000 002081B3 00000001 00000001 26 0 0 0 00 00000000 00000000
6 1 33 00006004 002081B3 00000002 00000002 27 1 0 0 00 00000000 00000000
6 1 33 00006008 002081B3 00000003 00000003 28 0 1 0 28 0000600C 00000006

// ==== sources.f ====
+incdir+.
ieu_pkg.sv
ieu_id.sv
ieu_ex.sv
ieu.sv
tb_ieu.sv

// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing
TOP   = tb_ieu
FLIST = sources.f

SRCS  = $(shell grep -v '^+' $(FLIST))
HDRS  = ieu_config.svh
BIN   = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir
